// ==== hw/scene_pkg.sv ====
package scene_pkg;

    localparam int DATA_W  = 16;
    localparam int INDEX_W = 8;   // Limits tables to 256 entries
    localparam int PROP_W  = 4;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [PROP_W-1:0]  prop_t;
    typedef logic [1:0]         material_t;

    typedef enum logic [2:0] {
        op_none,
        op_camera_set,
        op_light_set,
        op_tri_set,
        op_frame
    } op_t;

    typedef enum logic [1:0] {
        light_ambient,
        light_point,
        light_directional,
        light_spot
    } light_kind_t;

    // Property codes per record kind
    typedef enum logic [PROP_W-1:0] {
        cp_x_loc = 4'd0, cp_y_loc = 4'd1, cp_z_loc = 4'd2,
        cp_x_fwd = 4'd3, cp_y_fwd = 4'd4, cp_z_fwd = 4'd5,
        cp_fov   = 4'd6
    } camera_prop_t;

    typedef enum logic [PROP_W-1:0] {
        lp_kind   = 4'd0,
        lp_x_loc  = 4'd1, lp_y_loc = 4'd2, lp_z_loc = 4'd3,
        lp_colour = 4'd4,
        lp_intensity = 4'd5
    } light_prop_t;

    typedef enum logic [PROP_W-1:0] {
        tp_x1 = 4'd0, tp_y1 = 4'd1, tp_z1 = 4'd2,
        tp_x2 = 4'd3, tp_y2 = 4'd4, tp_z2 = 4'd5,
        tp_x3 = 4'd6, tp_y3 = 4'd7, tp_z3 = 4'd8,
        tp_colour   = 4'd9,
        tp_material = 4'd10
    } tri_prop_t;

    typedef struct packed {
        data_t x_loc, y_loc, z_loc;
        data_t x_fwd, y_fwd, z_fwd;
        data_t fov;
    } camera_t;   // 112 bits

    typedef struct packed {
        light_kind_t kind;
        data_t       x_loc, y_loc, z_loc;
        data_t       colour;
        data_t       intensity;
    } light_t;    // 82 bits

    typedef struct packed {
        data_t     x1, y1, z1;
        data_t     x2, y2, z2;
        data_t     x3, y3, z3;
        data_t     colour;
        material_t material;
    } triangle_t; // 162 bits

    typedef struct packed {
        op_t    op;
        index_t index;
        prop_t  prop;
        data_t  data;
    } scene_inst_t;

    // Write side of a table RAM
    typedef struct packed {
        logic   we;
        index_t addr;
        light_t data;
    } light_port_t;

    typedef struct packed {
        logic      we;
        index_t    addr;
        triangle_t data;
    } tri_port_t;

endpackage

// ==== hw/scene_mode_ctrl.sv ====
module scene_mode_ctrl import scene_pkg::*; (
    input  logic clk_100mhz,
    input  logic rst,
    input  logic inst_valid,
    input  op_t  inst_op,
    input  logic renderer_busy,
    output logic stall,
    output logic output_enabled,
    output logic inst_accept
);

    typedef enum logic [1:0] {
        st_writing,
        st_render_pending,
        st_render_busy
    } mode_t;

    mode_t state;

    assign stall          = (state != st_writing);
    assign output_enabled = (state != st_writing);   // Renderer may read while editing is held
    assign inst_accept    = inst_valid && (state == st_writing);

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            state <= st_writing;
        end else begin
            case (state)
                st_writing: begin
                    if (inst_accept && inst_op == op_frame) begin
                        state <= st_render_pending;
                    end
                end
                st_render_pending: begin
                    if (renderer_busy) begin
                        state <= st_render_busy;   // Renderer picked up the frame
                    end
                end
                st_render_busy: begin
                    if (!renderer_busy) begin
                        state <= st_writing;
                    end
                end
                default: state <= st_writing;
            endcase
        end
    end

endmodule

// ==== hw/property_merge.sv ====
module property_merge import scene_pkg::*; (
    input  scene_inst_t inst,
    input  camera_t     camera_in,
    input  light_t      light_in,
    input  triangle_t   tri_in,
    output camera_t     camera_out,
    output light_t      light_out,
    output triangle_t   tri_out
);

    always_comb begin
        camera_out = camera_in;
        light_out  = light_in;
        tri_out    = tri_in;

        case (inst.op)
            op_camera_set: begin
                case (inst.prop)
                    cp_x_loc: camera_out.x_loc = inst.data;
                    cp_y_loc: camera_out.y_loc = inst.data;
                    cp_z_loc: camera_out.z_loc = inst.data;
                    cp_x_fwd: camera_out.x_fwd = inst.data;
                    cp_y_fwd: camera_out.y_fwd = inst.data;
                    cp_z_fwd: camera_out.z_fwd = inst.data;
                    cp_fov:   camera_out.fov   = inst.data;
                    default: ;   // Unknown code leaves the record alone
                endcase
            end

            op_light_set: begin
                case (inst.prop)
                    lp_kind:      light_out.kind      = light_kind_t'(inst.data[1:0]);
                    lp_x_loc:     light_out.x_loc     = inst.data;
                    lp_y_loc:     light_out.y_loc     = inst.data;
                    lp_z_loc:     light_out.z_loc     = inst.data;
                    lp_colour:    light_out.colour    = inst.data;
                    lp_intensity: light_out.intensity = inst.data;
                    default: ;
                endcase
            end

            op_tri_set: begin
                case (inst.prop)
                    tp_x1:       tri_out.x1       = inst.data;
                    tp_y1:       tri_out.y1       = inst.data;
                    tp_z1:       tri_out.z1       = inst.data;
                    tp_x2:       tri_out.x2       = inst.data;
                    tp_y2:       tri_out.y2       = inst.data;
                    tp_z2:       tri_out.z2       = inst.data;
                    tp_x3:       tri_out.x3       = inst.data;
                    tp_y3:       tri_out.y3       = inst.data;
                    tp_z3:       tri_out.z3       = inst.data;
                    tp_colour:   tri_out.colour   = inst.data;
                    tp_material: tri_out.material = inst.data[1:0];
                    default: ;
                endcase
            end

            default: ;   // op_none and op_frame touch no record
        endcase
    end

endmodule

// ==== hw/scene_ram.sv ====
module scene_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16,
    localparam int AW   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic             clk_100mhz,
    input  logic             we,
    input  logic [AW-1:0]    waddr,
    input  logic [WIDTH-1:0] wdata,
    input  logic [AW-1:0]    raddr_a,
    output logic [WIDTH-1:0] rdata_a,
    input  logic [AW-1:0]    raddr_b,
    output logic [WIDTH-1:0] rdata_b
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Both reads sample the array before this edge's write lands (read-first)
    always_ff @(posedge clk_100mhz) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata_a <= mem[raddr_a];   // Edit pipeline side
        rdata_b <= mem[raddr_b];   // Renderer side
    end

endmodule

// ==== hw/scene_write_pipe.sv ====
module scene_write_pipe import scene_pkg::*; #(
    parameter int NUM_LIGHTS = 8,
    parameter int NUM_TRIS   = 64
) (
    input  logic        clk_100mhz,
    input  logic        rst,
    input  logic        inst_accept,
    input  scene_inst_t inst,
    input  light_t      light_rd,
    input  triangle_t   tri_rd,
    output light_port_t light_port,
    output tri_port_t   tri_port,
    output index_t      light_raddr,
    output index_t      tri_raddr,
    output camera_t     camera
);

    localparam int LIGHT_AW = (NUM_LIGHTS > 1) ? $clog2(NUM_LIGHTS) : 1;
    localparam int TRI_AW   = (NUM_TRIS > 1) ? $clog2(NUM_TRIS) : 1;

    // Stage one holds the instruction whose record is being read
    logic        s1_valid;
    scene_inst_t s1_inst;
    index_t      s1_addr;

    // Pending write that lands on the next edge
    logic      p_valid;
    op_t       p_op;
    index_t    p_addr;
    camera_t   p_camera;
    light_t    p_light;
    triangle_t p_tri;
    logic      p_writes;

    // Last completed write
    logic      l_valid;
    op_t       l_op;
    index_t    l_addr;
    camera_t   l_camera;
    light_t    l_light;
    triangle_t l_tri;

    camera_t   camera_q;
    logic      pend_hit;
    logic      last_hit;
    camera_t   camera_src;
    light_t    light_src;
    triangle_t tri_src;
    camera_t   camera_mrg;
    light_t    light_mrg;
    triangle_t tri_mrg;

    // Table read goes out on the accept edge with the index masked to the RAM depth
    assign light_raddr = index_t'(inst.index[LIGHT_AW-1:0]);
    assign tri_raddr   = index_t'(inst.index[TRI_AW-1:0]);

    always_comb begin
        case (s1_inst.op)
            op_light_set: s1_addr = index_t'(s1_inst.index[LIGHT_AW-1:0]);
            op_tri_set:   s1_addr = index_t'(s1_inst.index[TRI_AW-1:0]);
            default:      s1_addr = '0;   // Camera is a single record
        endcase
    end

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= inst_accept;
        end
        if (inst_accept) begin
            s1_inst <= inst;
        end
    end

    // Newest copy wins so the pending write beats the last write and storage
    assign pend_hit = p_valid && (p_op == s1_inst.op) && (p_addr == s1_addr);
    assign last_hit = l_valid && (l_op == s1_inst.op) && (l_addr == s1_addr);

    always_comb begin
        if (pend_hit) begin
            camera_src = p_camera;
            light_src  = p_light;
            tri_src    = p_tri;
        end else if (last_hit) begin
            camera_src = l_camera;
            light_src  = l_light;
            tri_src    = l_tri;
        end else begin
            camera_src = camera_q;
            light_src  = light_rd;
            tri_src    = tri_rd;
        end
    end

    property_merge u_merge (
        .inst       (s1_inst),
        .camera_in  (camera_src),
        .light_in   (light_src),
        .tri_in     (tri_src),
        .camera_out (camera_mrg),
        .light_out  (light_mrg),
        .tri_out    (tri_mrg)
    );

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            p_valid <= 1'b0;
        end else begin
            p_valid <= s1_valid;
        end
        if (s1_valid) begin
            p_op     <= s1_inst.op;
            p_addr   <= s1_addr;
            p_camera <= camera_mrg;
            p_light  <= light_mrg;
            p_tri    <= tri_mrg;
        end
    end

    assign p_writes = p_valid && (p_op == op_camera_set || p_op == op_light_set ||
                                  p_op == op_tri_set);

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            l_valid  <= 1'b0;
            camera_q <= '0;
        end else if (p_writes) begin
            l_valid <= 1'b1;
            if (p_op == op_camera_set) begin
                camera_q <= p_camera;
            end
        end
        if (p_writes) begin
            l_op     <= p_op;
            l_addr   <= p_addr;
            l_camera <= p_camera;
            l_light  <= p_light;
            l_tri    <= p_tri;
        end
    end

    assign light_port.we   = p_valid && (p_op == op_light_set);
    assign light_port.addr = p_addr;
    assign light_port.data = p_light;

    assign tri_port.we   = p_valid && (p_op == op_tri_set);
    assign tri_port.addr = p_addr;
    assign tri_port.data = p_tri;

    assign camera = camera_q;

endmodule

// ==== hw/scene_memory_bank.sv ====
module scene_memory_bank import scene_pkg::*; #(
    parameter int NUM_LIGHTS = 8,
    parameter int NUM_TRIS   = 64
) (
    input  logic        clk_100mhz,
    input  logic        rst,
    input  logic        inst_valid,
    input  scene_inst_t inst,
    input  logic        renderer_busy,
    input  index_t      light_read_addr,
    input  index_t      tri_read_addr,
    output logic        stall,
    output logic        output_enabled,
    output camera_t     camera,
    output light_t      light,
    output triangle_t   tri_data
);

    localparam int LIGHT_AW = (NUM_LIGHTS > 1) ? $clog2(NUM_LIGHTS) : 1;
    localparam int TRI_AW   = (NUM_TRIS > 1) ? $clog2(NUM_TRIS) : 1;

    logic        inst_accept;
    light_port_t light_port;
    tri_port_t   tri_port;
    index_t      light_raddr;
    index_t      tri_raddr;
    light_t      light_rd;
    triangle_t   tri_rd;

    scene_mode_ctrl u_mode_ctrl (
        .clk_100mhz     (clk_100mhz),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst_op        (inst.op),
        .renderer_busy  (renderer_busy),
        .stall          (stall),
        .output_enabled (output_enabled),
        .inst_accept    (inst_accept)
    );

    scene_write_pipe #(
        .NUM_LIGHTS (NUM_LIGHTS),
        .NUM_TRIS   (NUM_TRIS)
    ) u_write_pipe (
        .clk_100mhz  (clk_100mhz),
        .rst         (rst),
        .inst_accept (inst_accept),
        .inst        (inst),
        .light_rd    (light_rd),
        .tri_rd      (tri_rd),
        .light_port  (light_port),
        .tri_port    (tri_port),
        .light_raddr (light_raddr),
        .tri_raddr   (tri_raddr),
        .camera      (camera)
    );

    scene_ram #(
        .WIDTH ($bits(light_t)),
        .DEPTH (NUM_LIGHTS)
    ) light_ram (
        .clk_100mhz (clk_100mhz),
        .we         (light_port.we),
        .waddr      (light_port.addr[LIGHT_AW-1:0]),
        .wdata      (light_port.data),
        .raddr_a    (light_raddr[LIGHT_AW-1:0]),
        .rdata_a    (light_rd),
        .raddr_b    (light_read_addr[LIGHT_AW-1:0]),   // Renderer port
        .rdata_b    (light)
    );

    scene_ram #(
        .WIDTH ($bits(triangle_t)),
        .DEPTH (NUM_TRIS)
    ) tri_ram (
        .clk_100mhz (clk_100mhz),
        .we         (tri_port.we),
        .waddr      (tri_port.addr[TRI_AW-1:0]),
        .wdata      (tri_port.data),
        .raddr_a    (tri_raddr[TRI_AW-1:0]),
        .rdata_a    (tri_rd),
        .raddr_b    (tri_read_addr[TRI_AW-1:0]),
        .rdata_b    (tri_data)
    );

endmodule

// ==== bench/scene_memory_bank_props.sv ====
module scene_memory_bank_props import scene_pkg::*; #(
    parameter int NUM_LIGHTS = 8
) (
    input logic   clk_100mhz,
    input logic   rst,
    input logic   stall,
    input logic   output_enabled,
    input logic   inst_accept,
    input logic   light_we,
    input logic   tri_we,
    input index_t light_waddr
);

    timeunit 1ns;
    timeprecision 1ps;

    a_mode_levels: assert property (@(posedge clk_100mhz) disable iff (rst)
        stall == output_enabled)
        else $error("stall and output_enabled disagree");

    // A table write lands two edges after its accept
    a_write_after_accept: assert property (@(posedge clk_100mhz) disable iff (rst)
        (light_we || tri_we) |-> ($past(inst_accept, 1) || $past(inst_accept, 2)))
        else $error("table write without a recent accept");

    a_light_addr_range: assert property (@(posedge clk_100mhz) disable iff (rst)
        light_we |-> (int'(light_waddr) < NUM_LIGHTS))
        else $error("light write address beyond table depth");

    a_idle_after_reset: assert property (@(posedge clk_100mhz)
        ($past(rst) && !rst) |-> !stall)
        else $error("stall high right after reset");

endmodule

bind scene_memory_bank scene_memory_bank_props #(
    .NUM_LIGHTS (NUM_LIGHTS)
) u_props (
    .clk_100mhz     (clk_100mhz),
    .rst            (rst),
    .stall          (stall),
    .output_enabled (output_enabled),
    .inst_accept    (inst_accept),
    .light_we       (light_port.we),
    .tri_we         (tri_port.we),
    .light_waddr    (light_port.addr)
);

// ==== bench/scene_memory_bank_tb.sv ====
module scene_memory_bank_tb import scene_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LIGHTS   = 8;
    localparam int NUM_TRIS     = 64;
    localparam int CLK_PERIOD   = 10;
    localparam int SWEEP_CYCLES = 2 * NUM_TRIS + 4;   // Two cycles per readback index

    typedef struct packed {
        logic        valid;
        scene_inst_t inst;
        logic        busy;
        logic        exp_stall;   // Stall after the edge that samples this row
    } row_t;

    logic        clk_100mhz;
    logic        rst;
    logic        inst_valid;
    scene_inst_t inst;
    logic        renderer_busy;
    index_t      light_read_addr;
    index_t      tri_read_addr;
    logic        stall;
    logic        output_enabled;
    camera_t     camera;
    light_t      light;
    triangle_t   tri_data;

    row_t      rows[$];
    bit        table_ready;
    camera_t   model_camera;
    light_t    model_lights[NUM_LIGHTS];
    triangle_t model_tris[NUM_TRIS];
    bit        light_written[NUM_LIGHTS];
    bit        tri_written[NUM_TRIS];

    scene_memory_bank #(
        .NUM_LIGHTS (NUM_LIGHTS),
        .NUM_TRIS   (NUM_TRIS)
    ) DUT (
        .clk_100mhz      (clk_100mhz),
        .rst             (rst),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .renderer_busy   (renderer_busy),
        .light_read_addr (light_read_addr),
        .tri_read_addr   (tri_read_addr),
        .stall           (stall),
        .output_enabled  (output_enabled),
        .camera          (camera),
        .light           (light),
        .tri_data        (tri_data)
    );

    initial begin
        clk_100mhz = 1'b0;
        forever #(CLK_PERIOD / 2) clk_100mhz = ~clk_100mhz;
    end

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s got %0h expected %0h",
                     $time, name, got, expected);
            $display("Finished with errors");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic add_row(input logic valid, input op_t op, input int idx, input int prop,
                           input logic busy, input logic exp_stall);
        row_t r;
        r.valid      = valid;
        r.inst.op    = op;
        r.inst.index = index_t'(idx);
        r.inst.prop  = prop_t'(prop);
        r.inst.data  = data_t'($urandom);
        r.busy       = busy;
        r.exp_stall  = exp_stall;
        rows.push_back(r);
    endtask

    task automatic add_edit(input op_t op, input int idx, input int prop);
        add_row(1'b1, op, idx, prop, 1'b0, 1'b0);
    endtask

    task automatic add_wait(input logic busy, input logic exp_stall);
        add_row(1'b0, op_none, 0, 0, busy, exp_stall);
    endtask

    task automatic build_table();
        add_wait(1'b0, 1'b0);
        for (int p = 0; p < 6; p++) begin
            add_edit(op_light_set, 2, p);   // Same record every cycle
        end
        for (int p = 0; p < 11; p++) begin
            if (p < 6) begin
                add_edit(op_light_set, 3, p);   // Interleaved with one cycle between edits
            end
            add_edit(op_tri_set, 5, p);
        end
        for (int p = 0; p < 11; p++) begin
            add_edit(op_tri_set, 6, p);
            add_edit(op_none, 6, p);   // Gap filled by an ignored opcode
        end
        for (int p = 0; p < 7; p++) begin
            add_edit(op_camera_set, 0, p);
        end
        add_edit(op_camera_set, 0, 9);
        add_edit(op_light_set, 2, 4);
        add_edit(op_light_set, 2, 4);
        add_edit(op_tri_set, 5, 9);
        add_edit(op_light_set, 2, 1);
        add_edit(op_tri_set, 5, 10);
        add_edit(op_light_set, 3, 7);   // Unknown property codes
        add_edit(op_tri_set, 6, 12);
        add_edit(op_tri_set, 5, 15);
        add_edit(op_light_set, 2, 6);
        add_row(1'b0, op_light_set, 2, 1, 1'b0, 1'b0);
        add_row(1'b1, op_frame, 0, 0, 1'b0, 1'b1);
        add_row(1'b1, op_light_set, 2, 1, 1'b0, 1'b1);   // Dropped while stalled
        add_wait(1'b0, 1'b1);
        add_wait(1'b1, 1'b1);
        add_wait(1'b1, 1'b1);
        add_wait(1'b0, 1'b0);   // Editing resumes once the renderer is done
        for (int p = 0; p < 6; p++) begin
            add_edit(op_light_set, 5, p);
        end
        add_edit(op_tri_set, 6, 3);
        add_edit(op_camera_set, 0, 6);
        add_row(1'b1, op_frame, 0, 0, 1'b0, 1'b1);
        add_row(1'b1, op_tri_set, 5, 0, 1'b0, 1'b1);
        repeat (3) add_wait(1'b0, 1'b1);
    endtask

    task automatic apply_edit(input scene_inst_t in);
        int    i;
        data_t d;
        i = int'(in.index);
        d = in.data;
        case (in.op)
            op_camera_set: begin
                case (in.prop)
                    4'd0: model_camera.x_loc = d;
                    4'd1: model_camera.y_loc = d;
                    4'd2: model_camera.z_loc = d;
                    4'd3: model_camera.x_fwd = d;
                    4'd4: model_camera.y_fwd = d;
                    4'd5: model_camera.z_fwd = d;
                    4'd6: model_camera.fov   = d;
                    default: ;
                endcase
            end
            op_light_set: begin
                case (in.prop)
                    4'd0: model_lights[i].kind      = light_kind_t'(d[1:0]);
                    4'd1: model_lights[i].x_loc     = d;
                    4'd2: model_lights[i].y_loc     = d;
                    4'd3: model_lights[i].z_loc     = d;
                    4'd4: model_lights[i].colour    = d;
                    4'd5: model_lights[i].intensity = d;
                    default: ;
                endcase
                if (in.prop < 4'd6) light_written[i] = 1'b1;
            end
            op_tri_set: begin
                case (in.prop)
                    4'd0:  model_tris[i].x1       = d;
                    4'd1:  model_tris[i].y1       = d;
                    4'd2:  model_tris[i].z1       = d;
                    4'd3:  model_tris[i].x2       = d;
                    4'd4:  model_tris[i].y2       = d;
                    4'd5:  model_tris[i].z2       = d;
                    4'd6:  model_tris[i].x3       = d;
                    4'd7:  model_tris[i].y3       = d;
                    4'd8:  model_tris[i].z3       = d;
                    4'd9:  model_tris[i].colour   = d;
                    4'd10: model_tris[i].material = d[1:0];
                    default: ;
                endcase
                if (in.prop < 4'd11) tri_written[i] = 1'b1;
            end
            default: ;
        endcase
    endtask

    task automatic score_row(input int k);
        logic stall_before;
        stall_before = (k == 0) ? 1'b0 : rows[k-1].exp_stall;
        check_value("stall", 256'(stall), 256'(rows[k].exp_stall));
        check_value("output_enabled", 256'(output_enabled), 256'(rows[k].exp_stall));
        if (rows[k].valid && !stall_before) begin
            apply_edit(rows[k].inst);
        end
        // Edits in flight have landed one edge after stall rose
        if (k > 0 && rows[k].exp_stall && rows[k-1].exp_stall) begin
            check_value("camera", 256'(camera), 256'(model_camera));
        end
    endtask

    initial begin
        int n;
        void'($urandom(32'h43e3_6a92));
        rst             = 1'b1;
        inst_valid      = 1'b0;
        inst            = '0;
        renderer_busy   = 1'b0;
        light_read_addr = '0;
        tri_read_addr   = '0;
        model_camera    = '0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk_100mhz);
        rst <= 1'b0;
        @(negedge clk_100mhz);
        check_value("stall", 256'(stall), 256'(1'b0));
        check_value("output_enabled", 256'(output_enabled), 256'(1'b0));
        check_value("camera", 256'(camera), 256'(model_camera));

        n = rows.size();
        for (int i = 0; i <= n; i++) begin
            @(posedge clk_100mhz);
            if (i < n) begin
                inst_valid    <= rows[i].valid;
                inst          <= rows[i].inst;
                renderer_busy <= rows[i].busy;
            end else begin
                inst_valid <= 1'b0;
            end
            if (i > 0) begin
                @(negedge clk_100mhz);
                score_row(i - 1);
            end
        end

        for (int i = 0; i < NUM_TRIS; i++) begin
            @(posedge clk_100mhz);
            light_read_addr <= index_t'(i % NUM_LIGHTS);
            tri_read_addr   <= index_t'(i);
            @(posedge clk_100mhz);   // Port B has one cycle of latency
            @(negedge clk_100mhz);
            if (i < NUM_LIGHTS && light_written[i]) begin
                check_value("light", 256'(light), 256'(model_lights[i]));
            end
            if (tri_written[i]) begin
                check_value("tri", 256'(tri_data), 256'(model_tris[i]));
            end
        end

        $display("Finished with no errors");
        $finish;
    end

    initial begin
        wait (table_ready);
        #((rows.size() + SWEEP_CYCLES + 20) * CLK_PERIOD);
        $display("Watchdog timeout: the run did not reach its end in time");
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== compile.f ====
hw/scene_pkg.sv
hw/scene_mode_ctrl.sv
hw/property_merge.sv
hw/scene_ram.sv
hw/scene_write_pipe.sv
hw/scene_memory_bank.sv
bench/scene_memory_bank_props.sv
bench/scene_memory_bank_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := scene_memory_bank_tb
FILE_LIST  := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps -Wall
FAIL_MSG   := Finished with errors
PASS_MSG   := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "RESULT: FAIL"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then echo "RESULT: PASS"; \
	else echo "RESULT: FAIL, the run ended without a result line"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
